// File: rtl/phy_link_pkg.sv
// ------------------------------
// phy-link bus codes, speeds, request types, ack codes
// and the bus structs shared by the link blocks
// ------------------------------
package phy_link_pkg;

    localparam int STATUS_BITS  = 16;    // phy status transfer length
    localparam int LREQ_BITS    = 17;    // link request string
    localparam int QUADLET_BITS = 32;
    localparam int LEN_W        = 11;    // packet length in bits

    // ctl as driven by the link
    typedef enum logic [1:0] {
        LINK_CTL_IDLE = 2'b00,    // link done
        LINK_CTL_DATA = 2'b01,    // link sending data
        LINK_CTL_HOLD = 2'b10     // link holds the bus
    } link_ctl_e;

    // ctl as driven by the phy
    typedef enum logic [1:0] {
        PHY_CTL_IDLE = 2'b00,
        PHY_CTL_RECV = 2'b01,
        PHY_CTL_STAT = 2'b10,
        PHY_CTL_GRNT = 2'b11
    } phy_ctl_e;

    // speed code on data[3:1], data[0] dropped
    typedef enum logic [2:0] {
        RX_S100 = 3'b000,
        RX_S200 = 3'b001,
        RX_S400 = 3'b101
    } rx_speed_e;

    typedef enum logic [2:0] {
        LREQ_TX_IMM, LREQ_TX_ISO, LREQ_TX_PRI, LREQ_TX_FAIR,
        LREQ_REG_RD, LREQ_REG_WR, LREQ_ACCEL, LREQ_RES
    } lreq_type_e;

    typedef enum logic [3:0] {
        ACK_NONE = 4'h0,
        ACK_DONE = 4'h1,    // write complete
        ACK_PEND = 4'h2,    // read pending
        ACK_DATA = 4'hd     // data error
    } ack_code_e;

    typedef enum logic [3:0] {
        ST_IDLE, ST_STATUS, ST_RX_D_ON, ST_RX_DATA, ST_TX,
        ST_TX_DRIVE, ST_TX_DATA, ST_TX_DONE1, ST_TX_DONE2
    } link_state_e;

    typedef struct packed {
        logic [1:0] ctl;
        logic [7:0] data;
    } phy_bus_in_t;

    typedef struct packed {
        logic [1:0] ctl;
        logic [7:0] data;
        logic       ctl_oe;     // link owns ctl
        logic       data_oe;    // link owns data
    } phy_bus_out_t;

endpackage

// File: rtl/reg_map_pkg.sv
// ------------------------------
// register file address map and write port
// ------------------------------
package reg_map_pkg;

    localparam int ADDR_W = 16;

    // first quadlet of the transmit stream
    localparam logic [ADDR_W-1:0] ADDR_DEFAULT   = 16'h0000;
    // first quadlet of a received packet
    localparam logic [ADDR_W-1:0] ADDR_RESP_DATA = 16'h0040;

    // read data comes back combinationally from addr
    typedef struct packed {
        logic              wen;
        logic [ADDR_W-1:0] addr;
        logic [31:0]       wdata;
    } reg_wr_t;

endpackage

// File: rtl/lreq_serializer.sv
// ------------------------------
// link request string, shifted out on lreq
// ------------------------------
module lreq_serializer (
    input  logic                      sysclk,
    input  logic                      reset,
    input  logic                      trigger,
    input  phy_link_pkg::lreq_type_e  rtype,
    output logic                      lreq
);
    import phy_link_pkg::*;

    logic [LREQ_BITS-1:0] request;   // msb goes out first
    logic [2:0]           speed;

    // S400 only for the transmit request types
    always_comb begin
        case (rtype)
            LREQ_TX_IMM, LREQ_TX_ISO, LREQ_TX_PRI, LREQ_TX_FAIR: speed = 3'b100;
            default: speed = 3'b000;
        endcase
    end

    assign lreq = request[LREQ_BITS-1];

    always_ff @(posedge sysclk) begin
        if (!reset) begin
            request <= '0;                  // lreq low
        end else if (trigger) begin
            // start bits, type, speed, zero pad
            request <= {2'b01, rtype, speed, {(LREQ_BITS-8){1'b0}}};
        end else begin
            request <= {request[LREQ_BITS-2:0], 1'b0};
        end
    end

endmodule

// File: rtl/rx_deserializer.sv
// ------------------------------
// receive shifting at S100/S200/S400, quadlet writes and ack decode
// ------------------------------
module rx_deserializer (
    input  logic                            sysclk,
    input  logic                            reset,
    input  logic                            rx_start,
    input  phy_link_pkg::rx_speed_e         rx_speed,
    input  logic                            rx_shift,
    input  logic                            rx_end,
    input  logic [7:0]                      bus_data,
    output reg_map_pkg::reg_wr_t            rx_wr,
    output logic [phy_link_pkg::LEN_W-1:0]  resp_data_len,
    output phy_link_pkg::ack_code_e         ack_code
);
    import phy_link_pkg::*;
    import reg_map_pkg::*;

    logic [QUADLET_BITS-1:0] buffer;
    logic [QUADLET_BITS-1:0] buf_next;
    logic [QUADLET_BITS-1:0] wr_data;
    logic [LEN_W-1:0]        count;       // bits taken so far
    logic [LEN_W-1:0]        cnt_next;
    logic [LEN_W-1:0]        step;        // bits per cycle
    logic [ADDR_W-1:0]       wr_addr;
    logic [7:0]              data_rev;
    logic                    wr_en;
    logic                    quad_done;
    logic [3:0]              ack_hi;
    logic [3:0]              ack_lo;
    logic                    ack_ok;

    assign data_rev = {<<{bus_data}};     // bit 0 first on the wire

    always_comb begin
        buf_next = buffer;
        step     = '0;
        case (rx_speed)
            RX_S100: begin
                buf_next = {buffer[QUADLET_BITS-3:0], data_rev[7:6]};
                step     = LEN_W'(2);
            end
            RX_S200: begin
                buf_next = {buffer[QUADLET_BITS-5:0], data_rev[7:4]};
                step     = LEN_W'(4);
            end
            RX_S400: begin
                buf_next = {buffer[QUADLET_BITS-9:0], data_rev};
                step     = LEN_W'(8);
            end
            default: ;   // unknown speed, nothing taken
        endcase
    end

    assign cnt_next  = count + step;
    assign quad_done = rx_shift && (step != '0) && (cnt_next[4:0] == 5'd0);

    // ack is high nibble plus its inverse
    assign ack_hi = buffer[7:4];
    assign ack_lo = buffer[3:0];
    assign ack_ok = (ack_hi == ~ack_lo) &&
                    (ack_hi == ACK_DONE || ack_hi == ACK_PEND || ack_hi == ACK_DATA);

    assign rx_wr = '{wen: wr_en, addr: wr_addr, wdata: wr_data};

    always_ff @(posedge sysclk) begin
        if (!reset) begin
            wr_en         <= 1'b0;
            count         <= '0;
            resp_data_len <= '0;
            ack_code      <= ACK_NONE;
        end else begin
            wr_en <= quad_done;             // one pulse per quadlet
            if (rx_start) count <= '0;
            else if (rx_shift) count <= cnt_next;
            if (rx_end) begin
                resp_data_len <= count;
                if (count == LEN_W'(8) && ack_ok) ack_code <= ack_code_e'(ack_hi);
            end
        end
    end

    // payload, address steps after each write
    always_ff @(posedge sysclk) begin
        if (rx_start) wr_addr <= ADDR_RESP_DATA;
        else if (wr_en) wr_addr <= wr_addr + 1'b1;
        if (rx_shift) buffer <= buf_next;
        if (quad_done) wr_data <= buf_next;
    end

endmodule

// File: rtl/tx_serializer.sv
// ------------------------------
// transmit byte stream from register file quadlets
// ------------------------------
module tx_serializer (
    input  logic                                   sysclk,
    input  logic                                   reset,
    input  logic                                   tx_load,
    input  logic                                   tx_run,
    input  logic [phy_link_pkg::QUADLET_BITS-1:0]  reg_rdata,
    input  logic [phy_link_pkg::LEN_W-1:0]         pc_req_len,
    output logic [7:0]                             tx_byte,
    output logic [reg_map_pkg::ADDR_W-1:0]         tx_addr,
    output logic                                   tx_last
);
    import phy_link_pkg::*;
    import reg_map_pkg::*;

    logic [QUADLET_BITS-1:0] buffer;    // msb byte goes first
    logic [LEN_W-1:0]        count;     // bits sent
    logic                    boundary;  // last byte of a quadlet

    assign tx_byte  = {<<{buffer[QUADLET_BITS-1:QUADLET_BITS-8]}};  // reversed on wire
    assign tx_last  = (count == pc_req_len);
    assign boundary = (count[4:0] == 5'd24);

    // ------------------------------
    // counter and read address
    // ------------------------------
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            count   <= '0;
            tx_addr <= ADDR_DEFAULT;
        end else if (tx_load) begin
            count   <= '0;
            tx_addr <= ADDR_DEFAULT + 1'b1;    // first quadlet read here
        end else if (tx_run) begin
            if (tx_last) begin
                tx_addr <= ADDR_DEFAULT;       // ready for next grant
            end else begin
                count <= count + LEN_W'(8);
                if (boundary) tx_addr <= tx_addr + 1'b1;
            end
        end
    end

    // shift buffer, refilled at quadlet boundary
    always_ff @(posedge sysclk) begin
        if (tx_load) begin
            buffer <= reg_rdata;
        end else if (tx_run && !tx_last) begin
            if (boundary) buffer <= reg_rdata;
            else buffer <= {buffer[QUADLET_BITS-9:0], 8'h00};
        end
    end

endmodule

// File: rtl/link_state_ctl.sv
// ------------------------------
// phy-link state machine that owns the phy bus and register port
// ------------------------------
module link_state_ctl (
    input  logic                                  sysclk,
    input  logic                                  reset,
    input  phy_link_pkg::phy_bus_in_t             bus_in,
    output phy_link_pkg::phy_bus_out_t            bus_out,
    input  logic                                  pc_req_new,
    output logic                                  pc_req_done,
    output logic [phy_link_pkg::STATUS_BITS-1:0]  phy_status,
    output logic                                  rx_start,
    output phy_link_pkg::rx_speed_e               rx_speed,
    output logic                                  rx_shift,
    output logic                                  rx_end,
    input  reg_map_pkg::reg_wr_t                  rx_wr,
    output logic                                  tx_load,
    output logic                                  tx_run,
    input  logic [7:0]                            tx_byte,
    input  logic [reg_map_pkg::ADDR_W-1:0]        tx_addr,
    input  logic                                  tx_last,
    output reg_map_pkg::reg_wr_t                  reg_port,
    output logic                                  lreq_trig,
    output phy_link_pkg::lreq_type_e              lreq_type
);
    import phy_link_pkg::*;

    link_state_e            state;
    phy_ctl_e               ctl_in;     // phy side ctl decoded
    logic [STATUS_BITS-1:0] st_buff;    // status shift buffer
    logic [7:0]             st_count;   // status bits taken
    logic [1:0]             data2b;
    logic                   req_new_d;
    logic                   req_edge;   // registered rising edge
    logic                   req_go;
    logic                   rx_sel;     // rx side owns reg port

    assign ctl_in = phy_ctl_e'(bus_in.ctl);
    assign data2b = {bus_in.data[0], bus_in.data[1]};   // phy bits come reversed

    // ------------------------------
    // strobes to the rx and tx sides
    // ------------------------------
    assign rx_start = (state == ST_RX_D_ON) && (ctl_in == PHY_CTL_RECV) && !bus_in.data[0];
    assign rx_shift = (state == ST_RX_DATA) && (ctl_in == PHY_CTL_RECV);
    assign rx_end   = (state == ST_RX_DATA) && (ctl_in == PHY_CTL_IDLE);
    assign tx_load  = (state == ST_TX);          // reads ADDR_DEFAULT
    assign tx_run   = (state == ST_TX_DATA);
    assign req_go   = (state == ST_IDLE) && (ctl_in == PHY_CTL_IDLE) && req_edge;

    // last rx write can land after ctl went idle
    assign rx_sel = (state == ST_RX_DATA) || rx_wr.wen;

    always_comb begin
        reg_port = rx_wr;
        if (!rx_sel) begin
            reg_port.wen  = 1'b0;      // tx side only reads
            reg_port.addr = tx_addr;
        end
    end

    // ------------------------------
    // state machine
    // ------------------------------
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            state       <= ST_IDLE;
            bus_out     <= '0;         // phy drives both
            pc_req_done <= 1'b1;
            phy_status  <= '0;
            st_count    <= '0;
            lreq_trig   <= 1'b0;
            req_new_d   <= 1'b0;
            req_edge    <= 1'b0;
        end else begin
            req_new_d <= pc_req_new;
            req_edge  <= pc_req_new & ~req_new_d;
            lreq_trig <= req_go;
            if (req_go) pc_req_done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    case (ctl_in)
                        PHY_CTL_RECV: state <= ST_RX_D_ON;
                        PHY_CTL_GRNT: state <= ST_TX;          // bus granted
                        PHY_CTL_STAT: begin
                            state    <= ST_STATUS;
                            st_count <= 8'd2;                  // first two bits
                        end
                        default: state <= ST_IDLE;
                    endcase
                end
                ST_STATUS: begin
                    case (ctl_in)
                        PHY_CTL_STAT: st_count <= st_count + 8'd2;
                        PHY_CTL_RECV: state <= ST_RX_D_ON;     // cut short by rx
                        PHY_CTL_IDLE: begin
                            state <= ST_IDLE;
                            if (st_count == STATUS_BITS) phy_status <= st_buff;
                        end
                        default: state <= ST_IDLE;
                    endcase
                end
                ST_RX_D_ON: begin
                    if (ctl_in != PHY_CTL_RECV) state <= ST_IDLE;        // null packet
                    else if (!bus_in.data[0]) state <= ST_RX_DATA;     // speed cycle
                end
                ST_RX_DATA: if (ctl_in != PHY_CTL_RECV) state <= ST_IDLE;
                ST_TX: state <= ST_TX_DRIVE;
                ST_TX_DRIVE: begin
                    bus_out.ctl     <= LINK_CTL_HOLD;
                    bus_out.ctl_oe  <= 1'b1;
                    bus_out.data_oe <= 1'b1;
                    state           <= ST_TX_DATA;
                end
                ST_TX_DATA: begin
                    if (tx_last) begin
                        bus_out.ctl <= LINK_CTL_IDLE;
                        pc_req_done <= 1'b1;
                        state       <= ST_TX_DONE1;
                    end else begin
                        bus_out.ctl  <= LINK_CTL_DATA;
                        bus_out.data <= tx_byte;
                    end
                end
                ST_TX_DONE1: state <= ST_TX_DONE2;     // one more idle
                ST_TX_DONE2: begin
                    bus_out.ctl_oe  <= 1'b0;           // hand bus back
                    bus_out.data_oe <= 1'b0;
                    state           <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // status bits, latched speed and request type
    always_ff @(posedge sysclk) begin
        if (ctl_in == PHY_CTL_STAT) begin
            if (state == ST_IDLE) st_buff <= {{(STATUS_BITS-2){1'b0}}, data2b};
            else if (state == ST_STATUS) st_buff <= {st_buff[STATUS_BITS-3:0], data2b};
        end
        if (rx_start) rx_speed <= rx_speed_e'(bus_in.data[3:1]);
        if (req_go) lreq_type <= LREQ_TX_ISO;
    end

endmodule

// File: rtl/phy_link_top.sv
// ------------------------------
// phy-link controller top, wires the four blocks
// ------------------------------
module phy_link_top (
    input  logic                                   sysclk,
    input  logic                                   reset,
    input  phy_link_pkg::phy_bus_in_t              bus_in,
    output phy_link_pkg::phy_bus_out_t             bus_out,
    output logic                                   lreq,
    output reg_map_pkg::reg_wr_t                   reg_port,
    input  logic [phy_link_pkg::QUADLET_BITS-1:0]  reg_rdata,
    input  logic                                   pc_req_new,
    input  logic [phy_link_pkg::LEN_W-1:0]         pc_req_len,
    output logic                                   pc_req_done,
    output logic [phy_link_pkg::LEN_W-1:0]         resp_data_len,
    output phy_link_pkg::ack_code_e                ack_code,
    output logic [phy_link_pkg::STATUS_BITS-1:0]   phy_status
);
    import phy_link_pkg::*;
    import reg_map_pkg::*;

    // ctl to rx side
    logic       rx_start, rx_shift, rx_end;
    rx_speed_e  rx_speed;
    reg_wr_t    rx_wr;
    // ctl to tx side
    logic              tx_load, tx_run, tx_last;
    logic [7:0]        tx_byte;
    logic [ADDR_W-1:0] tx_addr;
    // link request
    logic       lreq_trig;
    lreq_type_e lreq_type;

    link_state_ctl u_ctl (
        .sysclk, .reset, .bus_in, .bus_out, .pc_req_new, .pc_req_done, .phy_status,
        .rx_start, .rx_speed, .rx_shift, .rx_end, .rx_wr,
        .tx_load, .tx_run, .tx_byte, .tx_addr, .tx_last,
        .reg_port, .lreq_trig, .lreq_type
    );

    rx_deserializer u_rx (
        .sysclk, .reset, .rx_start, .rx_speed, .rx_shift, .rx_end,
        .bus_data (bus_in.data),
        .rx_wr, .resp_data_len, .ack_code
    );

    tx_serializer u_tx (
        .sysclk, .reset, .tx_load, .tx_run, .reg_rdata, .pc_req_len,
        .tx_byte, .tx_addr, .tx_last
    );

    lreq_serializer u_lreq (
        .sysclk, .reset,
        .trigger (lreq_trig),
        .rtype   (lreq_type),
        .lreq
    );

endmodule

// File: include/tb_phy_tasks.svh
// ------------------------------
// phy-side bus drivers and payload LFSR
// ------------------------------
`ifndef TB_PHY_TASKS_SVH
`define TB_PHY_TASKS_SVH

// fibonacci lfsr, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// n fresh bits, one lfsr step each
function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        v = {v[30:0], lfsr_state[0]};
    end
    return v;
endfunction

function automatic int bits_per_cycle(input rx_speed_e speed);
    case (speed)
        RX_S100: return 2;
        RX_S200: return 4;
        default: return 8;    // S400
    endcase
endfunction

// bit q of the payload, msb of word 0 first
function automatic logic stream_bit(input int q);
    return rx_words[q / 32][31 - (q % 32)];
endfunction

// one phy cycle, driven after the edge
task automatic phy_cycle(input logic [1:0] ctl, input logic [7:0] data);
    @(posedge sysclk);
    bus_in <= '{ctl: ctl, data: data};
endtask

// status transfer, two bits per cycle, then idle
task automatic send_status(input logic [15:0] value, input int cycles);
    logic [7:0] d;
    for (int i = 0; i < cycles; i++) begin
        d    = 8'h00;
        d[0] = value[15 - 2 * i];   // first bit on data[0]
        d[1] = value[14 - 2 * i];
        phy_cycle(PHY_CTL_STAT, d);
    end
    phy_cycle(PHY_CTL_IDLE, 8'h00);
endtask

// data-on, speed code, payload chunks, idle
task automatic send_packet(input rx_speed_e speed, input int nbits);
    int         k;
    logic [7:0] d;
    k = bits_per_cycle(speed);
    phy_cycle(PHY_CTL_RECV, 8'h01);
    phy_cycle(PHY_CTL_RECV, 8'h01);
    phy_cycle(PHY_CTL_RECV, {4'h0, speed, 1'b0});
    for (int p = 0; p < nbits; p += k) begin
        d = 8'h00;
        for (int j = 0; j < k; j++) begin
            d[j] = stream_bit(p + j);   // reversed bit order on the wire
        end
        phy_cycle(PHY_CTL_RECV, d);
    end
    phy_cycle(PHY_CTL_IDLE, 8'h00);
endtask

task automatic send_grant();
    phy_cycle(PHY_CTL_GRNT, 8'h00);
    phy_cycle(PHY_CTL_IDLE, 8'h00);     // phy lets go of ctl
endtask

`endif

// File: sim/tb_phy_link.sv
// ------------------------------
// table driven testbench for the phy-link controller
// ------------------------------
module tb_phy_link;
    import phy_link_pkg::*;
    import reg_map_pkg::*;

    localparam int          CLK_PERIOD = 100;
    localparam int          NUM_ROWS   = 12;
    localparam int          MARGIN     = 4;
    localparam logic [31:0] LFSR_SEED  = 32'hdcf762c8;
    localparam logic [7:0]  ACK_BAD    = 8'h2e;     // high nibble not ~low

    typedef enum {T_STATUS, T_STATUS_SHORT, T_RX, T_ACK, T_ACK_BAD, T_TX} test_kind_e;

    typedef struct {
        test_kind_e kind;
        rx_speed_e  speed;
        int         quads;
        int         req_len;      // transmit bits
        ack_code_e  exp_ack;
    } test_row_t;

    test_row_t rows [NUM_ROWS] = '{
        '{T_STATUS,       RX_S400, 0, 0,  ACK_NONE},
        '{T_STATUS_SHORT, RX_S400, 0, 0,  ACK_NONE},
        '{T_RX,           RX_S400, 3, 0,  ACK_NONE},
        '{T_RX,           RX_S200, 3, 0,  ACK_NONE},
        '{T_RX,           RX_S100, 3, 0,  ACK_NONE},
        '{T_ACK,          RX_S400, 0, 0,  ACK_DONE},
        '{T_ACK,          RX_S400, 0, 0,  ACK_PEND},
        '{T_ACK,          RX_S400, 0, 0,  ACK_DATA},
        '{T_ACK_BAD,      RX_S400, 0, 0,  ACK_DATA},   // keeps last ack
        '{T_TX,           RX_S400, 0, 96, ACK_NONE},
        '{T_TX,           RX_S400, 0, 40, ACK_NONE},
        '{T_STATUS,       RX_S400, 0, 0,  ACK_NONE}
    };

    logic                    sysclk;
    logic                    reset;
    phy_bus_in_t             bus_in;
    phy_bus_out_t            bus_out;
    logic                    lreq;
    reg_wr_t                 reg_port;
    logic [QUADLET_BITS-1:0] reg_rdata;
    logic                    pc_req_new;
    logic [LEN_W-1:0]        pc_req_len;
    logic                    pc_req_done;
    logic [LEN_W-1:0]        resp_data_len;
    ack_code_e               ack_code;
    logic [STATUS_BITS-1:0]  phy_status;

    logic [31:0] mem [0:255];       // register file model
    logic [31:0] rx_words [0:7];    // receive payload
    logic [31:0] lfsr_state;
    logic [15:0] last_status;
    logic [15:0] wr_addr_q [$];     // write log
    logic [31:0] wr_data_q [$];
    int          errors;

    `include "tb_phy_tasks.svh"

    phy_link_top UUT (
        .sysclk, .reset, .bus_in, .bus_out, .lreq, .reg_port, .reg_rdata,
        .pc_req_new, .pc_req_len, .pc_req_done, .resp_data_len, .ack_code, .phy_status
    );

    assign reg_rdata = mem[reg_port.addr[7:0]];     // combinational read

    initial begin
        sysclk = 1'b0;
        forever #(CLK_PERIOD / 2) sysclk = ~sysclk;
    end

    // log every write strobe mid-cycle
    always @(negedge sysclk) begin
        if (reg_port.wen) begin
            wr_addr_q.push_back(reg_port.addr);
            wr_data_q.push_back(reg_port.wdata);
        end
    end

    function automatic int row_cycles(input test_row_t r);
        case (r.kind)
            T_RX:    return 10 + r.quads * 32 / bits_per_cycle(r.speed);
            T_TX:    return 60 + r.req_len / 8;
            default: return 14;
        endcase
    endfunction

    function automatic logic [7:0] reverse_byte(input logic [7:0] b);
        logic [7:0] r;
        for (int i = 0; i < 8; i++) begin
            r[i] = b[7 - i];
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got == exp) else begin
            errors++;
            $display("ERROR t=%0t %s expected %0h got %0h", $time, name, exp, got);
        end
    endtask

    task automatic run_status(input bit short_xfer);
        logic [31:0] tmp;
        tmp = lfsr_bits(16);
        send_status(tmp[15:0], short_xfer ? 6 : 8);
        if (!short_xfer) last_status = tmp[15:0];   // short one must not land
        repeat (2) @(posedge sysclk);
        @(negedge sysclk);
        check_value("phy_status", 32'(phy_status), 32'(last_status));
    endtask

    task automatic run_rx(input rx_speed_e speed, input int quads, input int nbits,
                          input ack_code_e exp_ack);
        int base;
        base = wr_addr_q.size();
        send_packet(speed, nbits);
        repeat (3) @(posedge sysclk);
        @(negedge sysclk);
        check_value("write count", 32'(wr_addr_q.size() - base), 32'(quads));
        for (int i = 0; i < quads && base + i < wr_addr_q.size(); i++) begin
            check_value("reg_port.addr", 32'(wr_addr_q[base + i]),
                        32'(ADDR_RESP_DATA) + 32'(i));
            check_value("reg_port.wdata", wr_data_q[base + i], rx_words[i]);
        end
        check_value("resp_data_len", 32'(resp_data_len), 32'(nbits));
        check_value("ack_code", 32'(ack_code), 32'(exp_ack));
    endtask

    task automatic run_ack(input logic [7:0] ack_byte, input ack_code_e exp_ack);
        logic [31:0] saved;
        saved       = rx_words[0];
        rx_words[0] = {ack_byte, 24'h0};
        run_rx(RX_S400, 0, 8, exp_ack);
        rx_words[0] = saved;
    endtask

    task automatic run_tx(input int len);
        logic [16:0] lreq_bits;
        logic [16:0] lreq_exp;
        logic [31:0] word;
        int          n;
        int          waited;
        n = len / 8;
        for (int q = 0; q < (n + 3) / 4; q++) begin
            mem[int'(ADDR_DEFAULT) + q] = lfsr_bits(32);
        end
        @(posedge sysclk);
        pc_req_len <= LEN_W'(len);
        pc_req_new <= 1'b1;
        waited = 0;
        do begin
            @(negedge sysclk);
            waited++;
        end while (pc_req_done && waited < 20);
        if (pc_req_done) begin
            errors++;
            $display("request edge never lowered pc_req_done at t=%0t", $time);
            return;
        end
        for (int b = 16; b >= 0; b--) begin
            @(negedge sysclk);
            lreq_bits[b] = lreq;
        end
        lreq_exp = {2'b01, 3'(LREQ_TX_ISO), 3'b100, 9'b0};   // isochronous at S400
        check_value("lreq", 32'(lreq_bits), 32'(lreq_exp));
        @(posedge sysclk);
        pc_req_new <= 1'b0;
        send_grant();
        waited = 0;
        do begin
            @(negedge sysclk);
            waited++;
        end while (!bus_out.ctl_oe && waited < 10);
        if (!bus_out.ctl_oe) begin
            errors++;
            $display("link never took the bus after grant at t=%0t", $time);
            return;
        end
        check_value("bus_out.ctl", 32'(bus_out.ctl), 32'(LINK_CTL_HOLD));
        check_value("bus_out.data_oe", 32'(bus_out.data_oe), 32'd1);
        for (int k = 0; k < n; k++) begin
            @(negedge sysclk);
            word = mem[int'(ADDR_DEFAULT) + k / 4];
            check_value("bus_out.ctl", 32'(bus_out.ctl), 32'(LINK_CTL_DATA));
            check_value("bus_out.data", 32'(bus_out.data),
                        32'(reverse_byte(word[31 - 8 * (k % 4) -: 8])));
        end
        @(negedge sysclk);
        check_value("bus_out.ctl", 32'(bus_out.ctl), 32'(LINK_CTL_IDLE));
        check_value("pc_req_done", 32'(pc_req_done), 32'd1);
        @(negedge sysclk);
        check_value("bus_out.ctl", 32'(bus_out.ctl), 32'(LINK_CTL_IDLE));
        check_value("bus_out.ctl_oe", 32'(bus_out.ctl_oe), 32'd1);
        @(negedge sysclk);
        check_value("bus_out.ctl_oe", 32'(bus_out.ctl_oe), 32'd0);
        check_value("bus_out.data_oe", 32'(bus_out.data_oe), 32'd0);
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        reset       = 1'b0;
        bus_in      = '0;
        pc_req_new  = 1'b0;
        pc_req_len  = '0;
        errors      = 0;
        lfsr_state  = LFSR_SEED;
        last_status = '0;
        for (int a = 0; a < 256; a++) begin
            mem[a] = {8'(a), ~8'(a), 8'(a) ^ 8'h5a, 8'(a * 3)};   // whole-address fill
        end
        for (int i = 0; i < 8; i++) begin
            rx_words[i] = lfsr_bits(32);    // shared by all speeds
        end
        repeat (10) @(posedge sysclk);
        reset <= 1'b1;
        @(negedge sysclk);
        check_value("bus_out.ctl_oe", 32'(bus_out.ctl_oe), 32'd0);
        check_value("bus_out.data_oe", 32'(bus_out.data_oe), 32'd0);
        check_value("reg_port.wen", 32'(reg_port.wen), 32'd0);
        check_value("lreq", 32'(lreq), 32'd0);
        check_value("pc_req_done", 32'(pc_req_done), 32'd1);
        check_value("ack_code", 32'(ack_code), 32'(ACK_NONE));
        for (int i = 0; i < NUM_ROWS; i++) begin
            case (rows[i].kind)
                T_STATUS:       run_status(1'b0);
                T_STATUS_SHORT: run_status(1'b1);
                T_RX:           run_rx(rows[i].speed, rows[i].quads,
                                       32 * rows[i].quads, rows[i].exp_ack);
                T_ACK:          run_ack({4'(rows[i].exp_ack), ~4'(rows[i].exp_ack)},
                                        rows[i].exp_ack);
                T_ACK_BAD:      run_ack(ACK_BAD, rows[i].exp_ack);
                default:        run_tx(rows[i].req_len);
            endcase
        end
        $display("rows run: %0d, errors: %0d", NUM_ROWS, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // watchdog with a budget from the table
    initial begin
        int total;
        total = 20;     // reset and settle
        #1;
        for (int i = 0; i < NUM_ROWS; i++) begin
            total += row_cycles(rows[i]);
        end
        #(total * MARGIN * CLK_PERIOD);
        $display("timeout: run still going after %0d cycles", total * MARGIN);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: phy_link.f
rtl/phy_link_pkg.sv
rtl/reg_map_pkg.sv
rtl/lreq_serializer.sv
rtl/rx_deserializer.sv
rtl/tx_serializer.sv
rtl/link_state_ctl.sv
rtl/phy_link_top.sv
+incdir+include
sim/tb_phy_link.sv

// File: run_sim.sh
#!/bin/sh
# build and run the phy-link testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_phy_link \
    -f phy_link.f

./obj_dir/Vtb_phy_link | tee sim.log

if grep -q "STATUS: FAIL" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation finished without failure"
